// File: hw/branch_pkg.sv
`default_nettype none

package branch_pkg;

  // ########################################
  // addresses and opcodes
  // ########################################

  localparam int ADDR_WIDTH = 16;
  typedef logic [ADDR_WIDTH-1:0] addr_t; // instruction address.

  localparam int JUMP_BITS = 4;
  typedef logic [JUMP_BITS-1:0] jop_t;

  localparam jop_t JMP_OP_NOP = 4'd0;
  localparam jop_t JMP_OP_J   = 4'd1;
  localparam jop_t JMP_OP_JR  = 4'd2;  // target comes from a register.
  localparam jop_t JMP_OP_JEQ = 4'd3;
  localparam jop_t JMP_OP_JNE = 4'd4;
  localparam jop_t JMP_OP_JL  = 4'd5;
  localparam jop_t JMP_OP_JLE = 4'd6;
  localparam jop_t JMP_OP_JG  = 4'd7;
  localparam jop_t JMP_OP_JGE = 4'd8;
  localparam jop_t JMP_OP_JZ  = 4'd9;
  localparam jop_t JMP_OP_JNZ = 4'd10; // codes above this decode as nop.

  // ########################################
  // pipeline flush masks
  // ########################################

  localparam int NUM_PIPE_MASKS = 4;
  typedef logic [NUM_PIPE_MASKS-1:0] flush_t;

  localparam flush_t PIPE_REG_PC     = 4'b0001;
  localparam flush_t PIPE_REG_IF_ID  = 4'b0010;
  localparam flush_t PIPE_REG_ID_EX  = 4'b0100;
  localparam flush_t PIPE_REG_EX_MEM = 4'b1000;

  localparam flush_t FLUSH_ALL = PIPE_REG_PC | PIPE_REG_IF_ID | PIPE_REG_ID_EX | PIPE_REG_EX_MEM;

  // ########################################
  // branch target table
  // ########################################

  localparam int NUM_ENTRIES = 8;
  typedef logic [NUM_ENTRIES-1:0] entry_mask_t;          // one bit per entry.
  typedef logic [$clog2(NUM_ENTRIES)-1:0] entry_idx_t;   // victim pointer width.

endpackage

`default_nettype wire

// File: hw/branch_resolve.sv
`timescale 1ns/1ps
`default_nettype none

module branch_resolve import branch_pkg::*; (
  input  wire logic  zero,
  input  wire logic  less,
  input  wire logic  greater,
  input  wire jop_t  jop,
  input  wire addr_t id_ex_reg_address,
  input  wire addr_t id_ex_imm_address,
  output flush_t     flush,
  output addr_t      jump_address
);

  // ########################################
  // flush decode
  // ########################################

  // conditional jumps either flush everything or nothing.
  always_comb begin
    case (jop)
      JMP_OP_NOP: flush = '0;
      JMP_OP_J:   flush = PIPE_REG_EX_MEM; // target already known in decode.
      JMP_OP_JR:  flush = FLUSH_ALL;

      JMP_OP_JEQ: flush = zero ? FLUSH_ALL : '0;
      JMP_OP_JNE: flush = !zero ? FLUSH_ALL : '0;

      JMP_OP_JL:  flush = less ? FLUSH_ALL : '0;
      JMP_OP_JLE: flush = (less || zero) ? FLUSH_ALL : '0;

      JMP_OP_JG:  flush = greater ? FLUSH_ALL : '0;
      JMP_OP_JGE: flush = (greater || zero) ? FLUSH_ALL : '0;

      JMP_OP_JZ:  flush = zero ? FLUSH_ALL : '0;
      JMP_OP_JNZ: flush = !zero ? FLUSH_ALL : '0;

      default:    flush = '0; // unused codes behave as nop.
    endcase
  end

  // ########################################
  // jump target
  // ########################################

  // only jr takes its target from the register file.
  always_comb begin
    if (jop == JMP_OP_JR) begin
      jump_address = id_ex_reg_address;
    end else begin
      jump_address = id_ex_imm_address;
    end
  end

endmodule

`default_nettype wire

// File: hw/btb_entry.sv
`timescale 1ns/1ps
`default_nettype none

module btb_entry import branch_pkg::*; (
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire logic  wr_en,
  input  wire addr_t wr_key,
  input  wire addr_t wr_val,
  input  wire addr_t rd_key,
  output logic       wr_hit,
  output logic       rd_hit,
  output addr_t      target
);

  logic  valid;
  addr_t key;

  // valid bit is the only control state here.
  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= 1'b0;
    end else if (wr_en) begin
      valid <= 1'b1;
    end
  end

  // key and target payload.
  always_ff @(posedge clk) begin
    if (wr_en) begin
      key    <= wr_key;
      target <= wr_val;
    end
  end

  // match outputs, gated by valid.
  assign wr_hit = valid && (key == wr_key);
  assign rd_hit = valid && (key == rd_key); // feeds the prediction mux.

endmodule

`default_nettype wire

// File: hw/btb_alloc.sv
`timescale 1ns/1ps
`default_nettype none

module btb_alloc import branch_pkg::*; (
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire logic        write,
  input  wire entry_mask_t wr_hit_mask,
  output entry_mask_t      entry_wr_en
);

  entry_idx_t  victim;     // next entry to replace.
  entry_mask_t victim_sel;
  logic        hit_any;

  assign hit_any    = |wr_hit_mask;
  assign victim_sel = entry_mask_t'(1) << victim;

  // an existing key is rewritten in place.
  // a new key goes to the victim slot.
  always_comb begin
    if (!write) begin
      entry_wr_en = '0;
    end else if (hit_any) begin
      entry_wr_en = wr_hit_mask;
    end else begin
      entry_wr_en = victim_sel;
    end
  end

  // round robin victim pointer.
  // only moves when a new entry is taken.
  always_ff @(posedge clk) begin
    if (rst) begin
      victim <= '0;
    end else if (write && !hit_any) begin
      victim <= entry_idx_t'(victim + 1'b1); // wraps at NUM_ENTRIES.
    end
  end

endmodule

`default_nettype wire

// File: hw/btb_select.sv
`timescale 1ns/1ps
`default_nettype none

module btb_select import branch_pkg::*; (
  input  wire entry_mask_t              rd_hit_mask,
  input  wire addr_t [NUM_ENTRIES-1:0]  targets,
  output logic                          take_branch,
  output addr_t                         branch_predict
);

  assign take_branch = |rd_hit_mask;

  // walk from the top down.
  // the lowest matching index is written last and wins.
  always_comb begin
    branch_predict = '0; // zero when nothing hits.
    for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
      if (rd_hit_mask[i]) begin
        branch_predict = targets[i];
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/branch_target_table.sv
`timescale 1ns/1ps
`default_nettype none

module branch_target_table import branch_pkg::*; (
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire logic  write,
  input  wire addr_t write_key,
  input  wire addr_t write_val,
  input  wire addr_t read_key,
  output logic       read_valid,
  output addr_t      read_val
);

  entry_mask_t             entry_wr_en;
  entry_mask_t             wr_hit_mask;
  entry_mask_t             rd_hit_mask;
  addr_t [NUM_ENTRIES-1:0] targets;

  // ########################################
  // write allocation
  // ########################################

  btb_alloc alloc0 (
    .clk         (clk),
    .rst         (rst),
    .write       (write),
    .wr_hit_mask (wr_hit_mask),
    .entry_wr_en (entry_wr_en)
  );

  // ########################################
  // entry array
  // ########################################

  // all entries see the same keys.
  // only the enabled one loads.
  for (genvar i = 0; i < NUM_ENTRIES; i++) begin : g_entry
    btb_entry entry (
      .clk    (clk),
      .rst    (rst),
      .wr_en  (entry_wr_en[i]),
      .wr_key (write_key),
      .wr_val (write_val),
      .rd_key (read_key),
      .wr_hit (wr_hit_mask[i]),
      .rd_hit (rd_hit_mask[i]),
      .target (targets[i])
    );
  end

  // ########################################
  // read side
  // ########################################

  btb_select select0 (
    .rd_hit_mask    (rd_hit_mask),
    .targets        (targets),
    .take_branch    (read_valid),
    .branch_predict (read_val)
  );

endmodule

`default_nettype wire

// File: hw/branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module branch_unit import branch_pkg::*; (
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire logic  zero,
  input  wire logic  less,
  input  wire logic  greater,
  input  wire jop_t  jop,
  input  wire addr_t id_ex_pc,          // key for table writes.
  input  wire addr_t id_ex_reg_address,
  input  wire addr_t id_ex_imm_address,
  input  wire addr_t pc,                // fetch pc for lookups.
  output flush_t     flush,
  output addr_t      jump_address,
  output addr_t      branch_predict,
  output logic       take_branch
);

  logic table_write;

  // ########################################
  // execute stage resolution
  // ########################################

  branch_resolve resolve0 (
    .zero              (zero),
    .less              (less),
    .greater           (greater),
    .jop               (jop),
    .id_ex_reg_address (id_ex_reg_address),
    .id_ex_imm_address (id_ex_imm_address),
    .flush             (flush),
    .jump_address      (jump_address)
  );

  // a full flush means a taken jump was missed. record it.
  // j only flushes ex/mem and never writes.
  assign table_write = (flush == FLUSH_ALL);

  // ########################################
  // target table
  // ########################################

  branch_target_table table0 (
    .clk        (clk),
    .rst        (rst),
    .write      (table_write),
    .write_key  (id_ex_pc),
    .write_val  (jump_address),
    .read_key   (pc),
    .read_valid (take_branch),
    .read_val   (branch_predict)
  );

endmodule

`default_nettype wire

// File: dv/branch_unit_properties.sv
`timescale 1ns/1ps
`default_nettype none

module branch_unit_properties import branch_pkg::*; (
  input wire logic   clk,
  input wire logic   rst,
  input wire jop_t   jop,
  input wire addr_t  id_ex_reg_address,
  input wire flush_t flush,
  input wire addr_t  jump_address,
  input wire logic   take_branch
);

  // only three mask shapes exist.
  a_flush_shape : assert property (@(posedge clk)
    (flush == '0) || (flush == PIPE_REG_EX_MEM) || (flush == FLUSH_ALL))
    else $error("flush mask %b is not zero, ex/mem only or full", flush);

  a_jr_target : assert property (@(posedge clk)
    (jop == JMP_OP_JR) |-> (jump_address == id_ex_reg_address))
    else $error("jr target %h differs from register address %h",
                jump_address, id_ex_reg_address);

  // valid bits are cleared by the reset edge.
  a_reset_clears : assert property (@(posedge clk) rst |=> !take_branch)
    else $error("take_branch high in the cycle after reset");

endmodule

bind branch_unit branch_unit_properties props0 (
  .clk               (clk),
  .rst               (rst),
  .jop               (jop),
  .id_ex_reg_address (id_ex_reg_address),
  .flush             (flush),
  .jump_address      (jump_address),
  .take_branch       (take_branch)
);

`default_nettype wire

// File: dv/tb_branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_branch_unit import branch_pkg::*; ();

  localparam int CLK_PERIOD    = 20;
  localparam int DRIVE_DELAY   = 2;
  localparam int CHECK_DELAY   = 16;   // samples 18 ns after the edge.
  localparam int RESET_CYCLES  = 3;
  localparam int RESET_TIMEOUT = 20;
  localparam int NUM_CYCLES    = 2000;
  localparam int RUN_TIMEOUT   = NUM_CYCLES + 50;
  localparam int POOL_SIZE     = 12;   // more keys than entries, so evictions happen.

  logic   clk;
  logic   rst;
  logic   zero;
  logic   less;
  logic   greater;
  jop_t   jop;
  addr_t  id_ex_pc;
  addr_t  id_ex_reg_address;
  addr_t  id_ex_imm_address;
  addr_t  pc;
  flush_t flush;
  addr_t  jump_address;
  addr_t  branch_predict;
  logic   take_branch;

  logic [31:0] rng_state;
  addr_t       addr_pool [POOL_SIZE];

  // reference copy of the table.
  logic        model_valid  [NUM_ENTRIES];
  addr_t       model_key    [NUM_ENTRIES];
  addr_t       model_target [NUM_ENTRIES];
  entry_idx_t  model_victim;

  int error_count;
  int check_count;
  int write_count;
  int evict_count;
  bit timed_out;

  branch_unit dut0 (
    .clk               (clk),
    .rst               (rst),
    .zero              (zero),
    .less              (less),
    .greater           (greater),
    .jop               (jop),
    .id_ex_pc          (id_ex_pc),
    .id_ex_reg_address (id_ex_reg_address),
    .id_ex_imm_address (id_ex_imm_address),
    .pc                (pc),
    .flush             (flush),
    .jump_address      (jump_address),
    .branch_predict    (branch_predict),
    .take_branch       (take_branch)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  // ########################################
  // random numbers
  // ########################################

  function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // upper bits of the lcg are the better ones.
  function automatic int random_below(input int n);
    logic [31:0] r;
    r = next_random();
    return int'(r[31:16]) % n;
  endfunction

  // ########################################
  // reference model
  // ########################################

  function automatic flush_t expected_flush(input jop_t op, input logic z, input logic l,
                                            input logic g);
    logic taken;
    taken = 1'b0;
    case (op)
      JMP_OP_JR:              taken = 1'b1;
      JMP_OP_JEQ, JMP_OP_JZ:  taken = z;
      JMP_OP_JNE, JMP_OP_JNZ: taken = !z;
      JMP_OP_JL:              taken = l;
      JMP_OP_JLE:             taken = l | z;
      JMP_OP_JG:              taken = g;
      JMP_OP_JGE:             taken = g | z;
      default:                taken = 1'b0;
    endcase
    if (op == JMP_OP_J) begin
      return PIPE_REG_EX_MEM; // unconditional, only ex/mem.
    end
    return taken ? FLUSH_ALL : flush_t'(0);
  endfunction

  function automatic addr_t expected_jump(input jop_t op, input addr_t reg_addr,
                                          input addr_t imm_addr);
    return (op == JMP_OP_JR) ? reg_addr : imm_addr;
  endfunction

  task automatic model_reset();
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      model_valid[i] = 1'b0;
    end
    model_victim = '0;
  endtask

  // lowest index wins, as in the hardware.
  task automatic model_lookup(input addr_t key, output logic hit, output addr_t val);
    hit = 1'b0;
    val = '0;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (!hit && model_valid[i] && (model_key[i] == key)) begin
        hit = 1'b1;
        val = model_target[i];
      end
    end
  endtask

  task automatic model_write(input addr_t key, input addr_t val);
    int slot;
    slot = -1;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (slot < 0 && model_valid[i] && (model_key[i] == key)) begin
        slot = i;
      end
    end
    if (slot < 0) begin
      slot = int'(model_victim);
      if (model_valid[slot]) begin
        evict_count++; // an older key is pushed out.
      end
      model_victim = model_victim + 1'b1;
    end
    model_valid[slot]  = 1'b1;
    model_key[slot]    = key;
    model_target[slot] = val;
    write_count++;
  endtask

  // ########################################
  // stimulus and checks
  // ########################################

  task automatic drive_random();
    int outcome;
    jop     = jop_t'(random_below(16));
    outcome = random_below(3); // exactly one compare flag.
    less    = (outcome == 0);
    zero    = (outcome == 1);
    greater = (outcome == 2);
    id_ex_pc          = addr_pool[random_below(POOL_SIZE)];
    pc                = addr_pool[random_below(POOL_SIZE)];
    id_ex_reg_address = addr_t'(next_random() >> 8);
    id_ex_imm_address = addr_t'(next_random() >> 8);
  endtask

  task automatic check_outputs(input int cycle);
    flush_t exp_flush;
    addr_t  exp_jump;
    logic   exp_take;
    addr_t  exp_predict;
    exp_flush = expected_flush(jop, zero, less, greater);
    exp_jump  = expected_jump(jop, id_ex_reg_address, id_ex_imm_address);
    model_lookup(pc, exp_take, exp_predict); // contents before this edge's write.
    if (flush !== exp_flush) begin
      $display("FAIL flush cycle %0d expected %b actual %b", cycle, exp_flush, flush);
      error_count++;
    end
    if (jump_address !== exp_jump) begin
      $display("FAIL jump_address cycle %0d expected %h actual %h", cycle, exp_jump,
               jump_address);
      error_count++;
    end
    if (take_branch !== exp_take) begin
      $display("FAIL take_branch cycle %0d expected %b actual %b", cycle, exp_take,
               take_branch);
      error_count++;
    end
    if (branch_predict !== exp_predict) begin
      $display("FAIL branch_predict cycle %0d expected %h actual %h", cycle, exp_predict,
               branch_predict);
      error_count++;
    end
    check_count = check_count + 4;
  endtask

  initial begin
    int      wait_count;
    int      cycle;
    realtime run_deadline;
    rng_state   = 32'd46081;
    error_count = 0;
    check_count = 0;
    write_count = 0;
    evict_count = 0;
    timed_out   = 1'b0;
    for (int i = 0; i < POOL_SIZE; i++) begin
      addr_pool[i] = addr_t'(16'h0400 + 16'(i) * 16'h0036);
    end

    rst               = 1'b1;
    zero              = 1'b0;
    less              = 1'b0;
    greater           = 1'b0;
    jop               = JMP_OP_NOP;
    id_ex_pc          = '0;
    id_ex_reg_address = '0;
    id_ex_imm_address = '0;
    pc                = '0;
    model_reset();

    wait_count = 0;
    while (wait_count < RESET_CYCLES) begin
      @(posedge clk);
      wait_count++;
    end
    #DRIVE_DELAY rst = 1'b0;

    // table must come out of reset empty.
    wait_count = 0;
    while (take_branch !== 1'b0 && wait_count < RESET_TIMEOUT) begin
      @(posedge clk);
      wait_count++;
    end
    if (take_branch !== 1'b0) begin
      $display("timeout: take_branch never went low after reset");
      error_count++;
      timed_out = 1'b1;
    end

    // the run gets a fixed budget of simulated time.
    cycle        = 0;
    run_deadline = $realtime + RUN_TIMEOUT * CLK_PERIOD;
    while (!timed_out && cycle < NUM_CYCLES) begin
      if ($realtime > run_deadline) begin
        $display("timeout: run loop did not finish its cycles in time");
        error_count++;
        timed_out = 1'b1;
      end else begin
        drive_random();
        #CHECK_DELAY;
        check_outputs(cycle);
        if (expected_flush(jop, zero, less, greater) == FLUSH_ALL) begin
          model_write(id_ex_pc, expected_jump(jop, id_ex_reg_address, id_ex_imm_address));
        end
        cycle++;
        @(posedge clk);
        #DRIVE_DELAY;
      end
    end

    $display("cycles %0d checks %0d errors %0d writes %0d evictions %0d",
             cycle, check_count, error_count, write_count, evict_count);
    if (error_count == 0 && !timed_out) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
hw/branch_pkg.sv
hw/branch_resolve.sv
hw/btb_entry.sv
hw/btb_alloc.sv
hw/btb_select.sv
hw/branch_target_table.sv
hw/branch_unit.sv
dv/branch_unit_properties.sv
dv/tb_branch_unit.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_branch_unit
FILELIST  = tb.f

SIM = obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the simulation, fail unless it passes"
	@echo "  clean  remove obj_dir"
	@echo "  help   show this list"

# build, run, and look for the pass line in the output.
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir
